// ==== design/dcache_pkg.sv ====
package dcache_pkg;

    //////////////////////////////////////////////////////////////////////
    // cache geometry
    //////////////////////////////////////////////////////////////////////

    // two ways, so one LRU bit per set is enough
    localparam int num_ways       = 2;
    localparam int way_idx_width  = 1;

    localparam int index_width    = 4;
    localparam int num_sets       = 1 << index_width;

    localparam int offset_width   = 2;
    localparam int words_per_line = 1 << offset_width;

    localparam int word_width     = 32;
    localparam int line_width     = word_width * words_per_line;

    // address bits left above index, word offset and byte offset
    localparam int tag_width      = 32 - index_width - offset_width - 2;

    //////////////////////////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////////////////////////

    // idle doubles as the lookup state for the buffered request
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_miss_addr = 3'd1,
        st_miss_data = 3'd2,
        st_wr_addr   = 3'd3,
        st_wr_data   = 3'd4
    } ctrl_state_t;

endpackage

// ==== design/dcache_req_buf.sv ====
`timescale 1ns/1ps

module dcache_req_buf
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  logic                    req_valid,
    input  logic                    req_wr,
    input  logic [31:0]             req_addr,
    input  logic [word_width-1:0]   req_wdata,
    input  logic [3:0]              req_wstrb,
    output logic                    buf_valid,
    output logic                    buf_wr,
    output logic [tag_width-1:0]    buf_tag,
    output logic [index_width-1:0]  buf_index,
    output logic [offset_width-1:0] buf_offset,
    output logic [word_width-1:0]   buf_wdata,
    output logic [3:0]              buf_wstrb
);

    // control part
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
            buf_wr    <= 1'b0;
        end else if (load) begin
            // an empty slot when nothing is offered
            buf_valid <= req_valid;
            buf_wr    <= req_wr;
        end
    end

    // payload, address split on capture
    always_ff @(posedge clk) begin
        if (load && req_valid) begin
            buf_tag    <= req_addr[31 -: tag_width];
            buf_index  <= req_addr[offset_width + 2 +: index_width];
            buf_offset <= req_addr[2 +: offset_width];
            buf_wdata  <= req_wdata;
            buf_wstrb  <= req_wstrb;
        end
    end

    // a write with no byte lanes would reach memory as a no-op
    assert property (@(posedge clk) disable iff (rst)
        load && req_valid && req_wr |=> buf_wstrb != 4'b0000)
        else $error("write captured with empty strobe");

endmodule

// ==== design/dcache_way.sv ====
`timescale 1ns/1ps

module dcache_way
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [index_width-1:0]  index,
    input  logic [tag_width-1:0]    tag,
    input  logic [offset_width-1:0] offset,
    input  logic [word_width-1:0]   wdata,
    input  logic [3:0]              wstrb,
    input  logic                    word_we,
    input  logic                    refill,
    input  logic [line_width-1:0]   rline,
    output logic                    hit,
    output logic [line_width-1:0]   line
);

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    logic [num_sets-1:0]   valid_q;
    logic [tag_width-1:0]  tag_q [num_sets];
    logic [line_width-1:0] data_q [num_sets];

    logic [word_width-1:0] old_word;
    logic [word_width-1:0] new_word;

    // lookup is combinational on the buffered index
    assign hit  = valid_q[index] && (tag_q[index] == tag);
    assign line = data_q[index];

    // byte merge for a store hit
    assign old_word = data_q[index][{offset, 5'd0} +: word_width];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            new_word[b*8 +: 8] = wstrb[b] ? wdata[b*8 +: 8] : old_word[b*8 +: 8];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // updates
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (refill) begin
            valid_q[index] <= 1'b1;
        end
    end

    // whole line on refill, one word on a store hit
    always_ff @(posedge clk) begin
        if (refill) begin
            tag_q[index]  <= tag;
            data_q[index] <= rline;
        end else if (word_we) begin
            data_q[index][{offset, 5'd0} +: word_width] <= new_word;
        end
    end

    // controller never refills a way it is also storing into
    assert property (@(posedge clk) disable iff (rst) !(refill && word_we))
        else $error("refill and word write in the same cycle");

endmodule

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    buf_valid,
    input  logic                    buf_wr,
    input  logic [tag_width-1:0]    buf_tag,
    input  logic [index_width-1:0]  buf_index,
    input  logic [offset_width-1:0] buf_offset,
    input  logic [word_width-1:0]   buf_wdata,
    input  logic [3:0]              buf_wstrb,
    input  logic [num_ways-1:0]     hit,
    input  logic [line_width-1:0]   line [num_ways],
    input  logic                    mem_addr_ok,
    input  logic                    mem_data_ok,
    input  logic [line_width-1:0]   mem_rline,
    output logic                    ready,
    output logic                    resp_valid,
    output logic [word_width-1:0]   resp_rdata,
    output logic [num_ways-1:0]     refill,
    output logic [num_ways-1:0]     word_we,
    output logic                    mem_req,
    output logic                    mem_wr,
    output logic [31:0]             mem_addr,
    output logic [word_width-1:0]   mem_wdata,
    output logic [3:0]              mem_wstrb
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // one bit per set, names the way to replace next
    logic [num_sets-1:0] lru_q;

    logic                     lookup;
    logic                     any_hit;
    logic                     hit_done;
    logic                     mem_done;
    logic [way_idx_width-1:0] hit_way;
    logic [way_idx_width-1:0] victim;
    logic [line_width-1:0]    sel_line;

    //////////////////////////////////////////////////////////////////////
    // hit decode
    //////////////////////////////////////////////////////////////////////

    assign lookup  = (state_q == st_idle) && buf_valid;
    assign any_hit = |hit;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit[w]) begin
                hit_way = way_idx_width'(w);
            end
        end
    end

    assign victim = lru_q[buf_index];

    // read hit answers in the lookup cycle
    assign hit_done = lookup && !buf_wr && any_hit;
    // miss refill or write completion
    assign mem_done = ((state_q == st_miss_data) || (state_q == st_wr_data)) && mem_data_ok;

    // buffer reloads on the finishing edge, so a refilled line is not answered twice
    assign ready      = ((state_q == st_idle) && (!buf_valid || hit_done)) || mem_done;
    assign resp_valid = hit_done || mem_done;

    // word from the returning line during a refill
    assign sel_line   = (state_q == st_miss_data) ? mem_rline : line[hit_way];
    assign resp_rdata = sel_line[{buf_offset, 5'd0} +: word_width];

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            refill[w]  = (state_q == st_miss_data) && mem_data_ok &&
                         (victim == way_idx_width'(w));
            word_we[w] = lookup && buf_wr && hit[w];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // LRU
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '0;
        end else if (lookup && any_hit) begin
            // store hits count as a use too
            lru_q[buf_index] <= ~hit_way;
        end else if (|refill) begin
            lru_q[buf_index] <= ~victim;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (buf_valid && buf_wr) begin
                    state_d = st_wr_addr;
                end else if (buf_valid && !any_hit) begin
                    state_d = st_miss_addr;
                end
            end
            st_miss_addr: begin
                if (mem_addr_ok) begin
                    state_d = st_miss_data;
                end
            end
            st_miss_data: begin
                if (mem_data_ok) begin
                    state_d = st_idle;
                end
            end
            st_wr_addr: begin
                if (mem_addr_ok) begin
                    state_d = st_wr_data;
                end
            end
            st_wr_data: begin
                if (mem_data_ok) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // memory bus
    //////////////////////////////////////////////////////////////////////

    // buffer is frozen while ready is low, so the fields hold by themselves
    assign mem_req   = (state_q == st_miss_addr) || (state_q == st_wr_addr);
    assign mem_wr    = buf_wr;
    assign mem_addr  = buf_wr ? {buf_tag, buf_index, buf_offset, 2'b00}
                              : {buf_tag, buf_index, {(offset_width + 2){1'b0}}};
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wr ? buf_wstrb : 4'b0000;

    // a second hit would mean one line cached in two ways
    assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
        else $error("more than one way hits");

    assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr) && $stable(mem_wr)
                                    && $stable(mem_wdata) && $stable(mem_wstrb))
        else $error("memory request dropped or changed before addr_ok");

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // pipeline side
    input  logic                  req_valid,
    input  logic                  req_wr,
    input  logic [31:0]           req_addr,
    input  logic [word_width-1:0] req_wdata,
    input  logic [3:0]            req_wstrb,
    output logic                  ready,
    output logic                  resp_valid,
    output logic [word_width-1:0] resp_rdata,
    // memory side
    output logic                  mem_req,
    output logic                  mem_wr,
    output logic [31:0]           mem_addr,
    output logic [word_width-1:0] mem_wdata,
    output logic [3:0]            mem_wstrb,
    input  logic                  mem_addr_ok,
    input  logic                  mem_data_ok,
    input  logic [line_width-1:0] mem_rline
);

    logic                    buf_valid;
    logic                    buf_wr;
    logic [tag_width-1:0]    buf_tag;
    logic [index_width-1:0]  buf_index;
    logic [offset_width-1:0] buf_offset;
    logic [word_width-1:0]   buf_wdata;
    logic [3:0]              buf_wstrb;

    logic [num_ways-1:0]     way_hit;
    logic [line_width-1:0]   way_line [num_ways];
    logic [num_ways-1:0]     way_refill;
    logic [num_ways-1:0]     way_word_we;

    // ready doubles as the buffer load enable
    dcache_req_buf req_buf_i (
        .clk(clk), .rst(rst), .load(ready),
        .req_valid(req_valid), .req_wr(req_wr), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .buf_valid(buf_valid), .buf_wr(buf_wr), .buf_tag(buf_tag),
        .buf_index(buf_index), .buf_offset(buf_offset),
        .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb)
    );

    for (genvar g = 0; g < num_ways; g++) begin : gen_ways
        dcache_way way_i (
            .clk(clk), .rst(rst),
            .index(buf_index), .tag(buf_tag), .offset(buf_offset),
            .wdata(buf_wdata), .wstrb(buf_wstrb),
            .word_we(way_word_we[g]), .refill(way_refill[g]), .rline(mem_rline),
            .hit(way_hit[g]), .line(way_line[g])
        );
    end

    dcache_ctrl ctrl_i (
        .clk(clk), .rst(rst),
        .buf_valid(buf_valid), .buf_wr(buf_wr), .buf_tag(buf_tag),
        .buf_index(buf_index), .buf_offset(buf_offset),
        .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb),
        .hit(way_hit), .line(way_line),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_rline(mem_rline),
        .ready(ready), .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .refill(way_refill), .word_we(way_word_we),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb)
    );

endmodule

// ==== verification/mem_model.sv ====
`timescale 1ns/1ps

module mem_model
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_req,
    input  logic                  mem_wr,
    input  logic [31:0]           mem_addr,
    input  logic [word_width-1:0] mem_wdata,
    input  logic [3:0]            mem_wstrb,
    output logic                  mem_addr_ok,
    output logic                  mem_data_ok,
    output logic [line_width-1:0] mem_rline
);

    localparam int max_delay = 3;

    integer seed = 32'hcf5b;

    // holds only written words keyed by word address
    logic [31:0] store [logic [31:0]];

    logic        busy;
    int unsigned wait_cnt;

    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (store.exists(a)) begin
            return store[a];
        end
        // untouched words start as the inverted byte address
        return ~a;
    endfunction

    function automatic logic [line_width-1:0] read_line(input logic [31:0] a);
        logic [line_width-1:0] l;
        logic [31:0]           base;
        base = {a[31:offset_width+2], {(offset_width+2){1'b0}}};
        for (int w = 0; w < words_per_line; w++) begin
            l[w*32 +: 32] = read_word(base + 32'(w * 4));
        end
        return l;
    endfunction

    task automatic write_word(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        logic [31:0] w;
        w = read_word(a);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        store[a] = w;
    endtask

    function automatic int unsigned next_delay();
        return $unsigned($random(seed)) % (max_delay + 1);
    endfunction

    // bus outputs start low before the first reset edge
    initial begin
        mem_addr_ok <= 1'b0;
        mem_data_ok <= 1'b0;
        mem_rline   <= '0;
    end

    // address phase and data phase each follow a random wait
    always @(posedge clk) begin
        if (rst) begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rline   <= '0;
            busy        <= 1'b0;
            wait_cnt    <= next_delay();
        end else begin
            mem_data_ok <= 1'b0;
            if (mem_addr_ok) begin
                // handshake completes at this edge
                mem_addr_ok <= 1'b0;
                if (mem_wr) begin
                    write_word({mem_addr[31:2], 2'b00}, mem_wdata, mem_wstrb);
                end else begin
                    mem_rline <= read_line(mem_addr);
                end
                busy     <= 1'b1;
                wait_cnt <= next_delay();
            end else if (busy) begin
                if (wait_cnt == 0) begin
                    mem_data_ok <= 1'b1;
                    busy        <= 1'b0;
                    wait_cnt    <= next_delay();
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (mem_req) begin
                if (wait_cnt == 0) begin
                    mem_addr_ok <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

// ==== verification/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int max_ops       = 64;
    localparam int fields        = 6;
    localparam int cycles_per_op = 40;
    localparam int end_kind      = 2;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    logic                  req_wr;
    logic [31:0]           req_addr;
    logic [word_width-1:0] req_wdata;
    logic [3:0]            req_wstrb;
    logic                  ready;
    logic                  resp_valid;
    logic [word_width-1:0] resp_rdata;
    logic                  mem_req;
    logic                  mem_wr;
    logic [31:0]           mem_addr;
    logic [word_width-1:0] mem_wdata;
    logic [3:0]            mem_wstrb;
    logic                  mem_addr_ok;
    logic                  mem_data_ok;
    logic [line_width-1:0] mem_rline;

    // six fields per operation as laid out in the golden file
    logic [31:0] golden [max_ops*fields];

    int num_ops;
    int cycle_count = 0;
    int cycle_limit = 0;
    int rd_count = 0;
    int wr_count = 0;

    // bus fields seen at the last address handshake
    logic [31:0]           bus_addr;
    logic [word_width-1:0] bus_wdata;
    logic [3:0]            bus_wstrb;

    dcache_top dut_i (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_wr(req_wr), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .ready(ready), .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_rline(mem_rline)
    );

    mem_model mem_i (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_rline(mem_rline)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus monitor and timeout
    //////////////////////////////////////////////////////////////////////

    // every read handshake on the bus is a line fetch for a miss
    always @(posedge clk) begin
        if (!rst && mem_req && mem_addr_ok) begin
            bus_addr  = mem_addr;
            bus_wdata = mem_wdata;
            bus_wstrb = mem_wstrb;
            if (mem_wr) begin
                wr_count++;
            end else begin
                rd_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            stop_on_error($sformatf("timeout: run did not end within %0d cycles", cycle_limit));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // one golden operation entered and left on a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic run_op(input int n);
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] exp_rdata;
        logic [31:0] exp_miss;
        logic [31:0] exp_addr;
        int          rd_start;
        int          wr_start;
        int          gap;
        string       name;
        kind      = golden[n*fields];
        addr      = golden[n*fields + 1];
        wdata     = golden[n*fields + 2];
        wstrb     = golden[n*fields + 3][3:0];
        exp_rdata = golden[n*fields + 4];
        exp_miss  = golden[n*fields + 5];
        name      = $sformatf("op%0d %s %08h", n, (kind == 1) ? "write" : "read", addr);
        req_valid = 1'b1;
        req_wr    = kind[0];
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = wstrb;
        while (!ready) begin
            @(negedge clk);
        end
        rd_start = rd_count;
        wr_start = wr_count;
        @(negedge clk);
        req_valid = 1'b0;
        gap = 0;
        while (!resp_valid) begin
            @(negedge clk);
            gap++;
        end
        if (kind == 1) begin
            // writes go out at the word address
            exp_addr = {addr[31:2], 2'b00};
            assert (wr_count - wr_start == 1) else
                stop_on_error($sformatf("mismatch %s memory writes: expected 1, actual %0d",
                                        name, wr_count - wr_start));
            assert (rd_count == rd_start) else
                stop_on_error($sformatf("mismatch %s line fetches: expected 0, actual %0d",
                                        name, rd_count - rd_start));
            assert (bus_addr == exp_addr) else
                stop_on_error($sformatf("mismatch %s write address: expected %08h, actual %08h",
                                        name, exp_addr, bus_addr));
            assert (bus_wdata == wdata) else
                stop_on_error($sformatf("mismatch %s write data: expected %08h, actual %08h",
                                        name, wdata, bus_wdata));
            assert (bus_wstrb == wstrb) else
                stop_on_error($sformatf("mismatch %s write strobe: expected %h, actual %h",
                                        name, wstrb, bus_wstrb));
        end else begin
            // line fetches are aligned to the 16-byte line
            exp_addr = {addr[31:4], 4'b0000};
            assert (resp_rdata == exp_rdata) else
                stop_on_error($sformatf("mismatch %s: expected %08h, actual %08h",
                                        name, exp_rdata, resp_rdata));
            assert (rd_count - rd_start == int'(exp_miss)) else
                stop_on_error($sformatf("mismatch %s line fetches: expected %0d, actual %0d",
                                        name, exp_miss, rd_count - rd_start));
            assert (exp_miss == 0 || bus_addr == exp_addr) else
                stop_on_error($sformatf("mismatch %s fetch address: expected %08h, actual %08h",
                                        name, exp_addr, bus_addr));
            // a hit answers in the cycle right after acceptance
            assert (exp_miss != 0 || gap == 0) else
                stop_on_error($sformatf("%s hit response came %0d cycles late", name, gap));
        end
    endtask

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req_wr    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        num_ops   = 0;
        $readmemh("verification/dcache_golden.txt", golden);
        while (num_ops < max_ops && golden[num_ops*fields] != end_kind) begin
            num_ops++;
        end
        assert (num_ops > 0 && num_ops < max_ops) else
            stop_on_error("golden file holds no operations or lacks its end line");
        cycle_limit = num_ops * cycles_per_op + 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (ready && !mem_req && !resp_valid) else
            stop_on_error("after reset ready is low or mem_req or resp_valid is high");
        for (int i = 0; i < num_ops; i++) begin
            run_op(i);
        end
        @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== verification/dcache_golden.txt ====
// kind addr wdata wstrb rdata miss, all hex; kind 0 read, 1 write, 2 end of list
// untouched memory words hold the inverted byte address; rdata and miss unused on writes
0 00000100 00000000 0 fffffeff 1
0 0000010c 00000000 0 fffffef3 0
0 00000104 00000000 0 fffffefb 0
0 00000108 00000000 0 fffffef7 0
1 00000104 11223344 3 00000000 0
0 00000104 00000000 0 ffff3344 0
1 00000108 aabbccdd c 00000000 0
0 00000108 00000000 0 aabbfef7 0
1 0000010c 01020304 f 00000000 0
0 0000010c 00000000 0 01020304 0
// write miss, no allocation
1 00002230 55667788 6 00000000 0
0 00002230 00000000 0 ff6677cf 1
0 00002234 00000000 0 ffffddcb 0
// three tags in set 5
0 00001050 00000000 0 ffffefaf 1
0 00002054 00000000 0 ffffdfab 1
0 00001058 00000000 0 ffffefa7 0
0 0000305c 00000000 0 ffffcfa3 1
0 00003050 00000000 0 ffffcfaf 0
0 00002050 00000000 0 ffffdfaf 1
0 00001050 00000000 0 ffffefaf 1
0 00002058 00000000 0 ffffdfa7 0
1 00002058 deadbeef 1 00000000 0
0 00002058 00000000 0 ffffdfef 0
0 00003058 00000000 0 ffffcfa7 1
0 00001050 00000000 0 ffffefaf 1
0 00002058 00000000 0 ffffdfef 1
0 0000305c 00000000 0 ffffcfa3 1
0 0000205c 00000000 0 ffffdfa3 0
// mixed traffic over other sets
0 00000100 00000000 0 fffffeff 0
0 0000ff04 00000000 0 ffff00fb 1
0 0000010c 00000000 0 01020304 0
0 0000ff0c 00000000 0 ffff00f3 0
1 0000fff0 12345678 f 00000000 0
0 0000fff0 00000000 0 12345678 1
1 0000fff0 9abcdef0 8 00000000 0
0 0000fff0 00000000 0 9a345678 0
0 0000fffc 00000000 0 ffff0003 0
0 00002234 00000000 0 ffffddcb 0
2 00000000 00000000 0 00000000 0

// ==== sim.f ====
design/dcache_pkg.sv
design/dcache_req_buf.sv
design/dcache_way.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verification/mem_model.sv
verification/tb_dcache.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_dcache with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_dcache -o sim_dcache
	./obj_dir/sim_dcache > $(LOG) 2>&1; cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) && echo "test passed" || { echo "test failed"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
